// ==== fc_engine.f ====
src/fc_pkg.sv
src/word_sram.sv
src/mem_arbiter.sv
src/stream_loader.sv
src/mac_lane.sv
src/fc_sequencer.sv
src/fc_engine.sv
verification/fc_engine_properties.sv
verification/fc_engine_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the fc engine testbench with Verilator, run it, then decide
# pass or fail from the simulation log

cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert -Wno-fatal \
  --top-module fc_engine_tb -f fc_engine.f &&
{ ./obj_dir/Vfc_engine_tb +verilator+error+limit+100 > sim.log 2>&1 || true; } &&
grep -q "^TEST PASS$" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }

// ==== src/fc_engine.sv ====
// top level of the int8 fully connected layer engine
// host loads features, bias and weights over the input stream, then
// a compute command returns four requantized neuron bytes in one word

`default_nettype none
`timescale 1ns/1ps

module fc_engine
  import fc_pkg::*;
#(
  parameter  int MAX_WORDS = 16,
  localparam int SIZE_W    = $clog2(MAX_WORDS + 1)
) (
  input  logic              clk,
  input  logic              rstn,
  input  cmd_t              cmd,
  input  logic              start,
  input  logic [SIZE_W-1:0] size,
  input  logic              in_valid,
  input  word_t             in_data,
  output logic              in_ready,
  output logic              out_valid,
  output word_t             out_data,
  input  logic              out_ready,
  output logic              busy
);

  localparam int ADDR_W = $clog2(mem_words(MAX_WORDS));

  // loader and sequencer to arbiter
  logic              ld_req, ld_we, ld_gnt;
  logic [ADDR_W-1:0] ld_addr;
  word_t             ld_wdata;
  logic              sq_req, sq_gnt;
  logic [ADDR_W-1:0] sq_addr;
  word_t             sq_rdata;

  // arbiter to memory
  logic              mem_en, mem_we;
  logic [ADDR_W-1:0] mem_addr;
  word_t             mem_wdata, mem_rdata;

  // lanes
  logic                   lane_valid, lane_first, lane_last;
  operand_t [N_LANES-1:0] lane_a, lane_b;
  acc_t [N_LANES-1:0]     lane_acc;
  logic [N_LANES-1:0]     lane_acc_valid;

  logic load_busy, comp_busy;

  assign busy = load_busy | comp_busy;

  stream_loader #(.MAX_WORDS(MAX_WORDS)) u_loader (
    .clk, .rstn, .cmd, .start, .size,
    .in_valid, .in_data, .in_ready,
    .ld_req, .ld_we, .ld_addr, .ld_wdata, .ld_gnt,
    .load_busy
  );

  fc_sequencer #(.MAX_WORDS(MAX_WORDS)) u_seq (
    .clk, .rstn, .cmd, .start, .size,
    .sq_req, .sq_addr, .sq_gnt, .sq_rdata,
    .lane_valid, .lane_first, .lane_last, .lane_a, .lane_b,
    .lane_acc, .lane_acc_valid,
    .out_valid, .out_data, .out_ready,
    .comp_busy
  );

  mem_arbiter #(.MAX_WORDS(MAX_WORDS)) u_arb (
    .clk, .rstn,
    .ld_req, .ld_we, .ld_addr, .ld_wdata, .ld_gnt,
    .sq_req, .sq_addr, .sq_gnt, .sq_rdata,
    .en(mem_en), .we(mem_we), .addr(mem_addr), .wdata(mem_wdata), .rdata(mem_rdata)
  );

  word_sram #(.MAX_WORDS(MAX_WORDS)) u_sram (
    .clk,
    .en(mem_en), .we(mem_we), .addr(mem_addr), .wdata(mem_wdata), .rdata(mem_rdata)
  );

  for (genvar n = 0; n < N_LANES; n++) begin : g_lane
    mac_lane u_lane (
      .clk, .rstn,
      .valid(lane_valid), .first(lane_first), .last(lane_last),
      .a(lane_a[n]), .b(lane_b[n]),
      .acc(lane_acc[n]), .acc_valid(lane_acc_valid[n])
    );
  end

endmodule

`default_nettype wire

// ==== src/fc_pkg.sv ====
// shared widths, operand types and host command codes of the fc engine
// every RTL module of the engine imports this package
// memory layout helpers live here so loader, sequencer and memory agree

`default_nettype none

package fc_pkg;

  localparam int DATA_W  = 32;  // memory and stream word
  localparam int BYTE_W  = 8;   // one int8 operand
  localparam int N_LANES = 4;   // output neurons, one MAC lane each
  localparam int ACC_W   = 28;

  // requantization window is bits QUANT_LIMIT_BIT..QUANT_SHIFT of the sum
  localparam int QUANT_SHIFT     = 6;
  localparam int QUANT_LIMIT_BIT = 12;

  typedef logic        [DATA_W-1:0] word_t;     // four packed bytes
  typedef logic signed [BYTE_W-1:0] operand_t;
  typedef logic signed [ACC_W-1:0]  acc_t;

  typedef enum logic [1:0] {
    CMD_LOAD_FEAT   = 2'd0,
    CMD_LOAD_BIAS   = 2'd1,
    CMD_LOAD_WEIGHT = 2'd2,
    CMD_COMPUTE     = 2'd3
  } cmd_t;

  // weights of neuron n at n*max_words, then the bias word, then features
  function automatic int mem_words(input int max_words);
    return 5 * max_words + 1;
  endfunction

  function automatic int bias_base(input int max_words);
    return 4 * max_words;
  endfunction

  function automatic int feat_base(input int max_words);
    return 4 * max_words + 1;
  endfunction

endpackage

`default_nettype wire

// ==== src/fc_sequencer.sv ====
// compute control of the fc engine
// fetches the bias word, then per feature word the four weight words,
// issues byte pairs to the lanes, adds bias, requantizes and sends
// the packed result on the output stream

`default_nettype none
`timescale 1ns/1ps

module fc_sequencer
  import fc_pkg::*;
#(
  parameter  int MAX_WORDS = 16,
  localparam int ADDR_W    = $clog2(mem_words(MAX_WORDS)),
  localparam int SIZE_W    = $clog2(MAX_WORDS + 1)
) (
  input  logic                   clk,
  input  logic                   rstn,
  input  cmd_t                   cmd,
  input  logic                   start,
  input  logic [SIZE_W-1:0]      size,
  output logic                   sq_req,
  output logic [ADDR_W-1:0]      sq_addr,
  input  logic                   sq_gnt,
  input  word_t                  sq_rdata,
  output logic                   lane_valid,
  output logic                   lane_first,
  output logic                   lane_last,
  output operand_t [N_LANES-1:0] lane_a,
  output operand_t [N_LANES-1:0] lane_b,
  input  acc_t [N_LANES-1:0]     lane_acc,
  input  logic [N_LANES-1:0]     lane_acc_valid,
  output logic                   out_valid,
  output word_t                  out_data,
  input  logic                   out_ready,
  output logic                   comp_busy
);

  localparam int N_BYTES = DATA_W / BYTE_W;
  localparam int K_W     = $clog2(N_BYTES);
  localparam int NRN_W   = $clog2(N_LANES);

  typedef enum logic [2:0] {
    S_IDLE, S_BIAS, S_FEAT, S_WGT, S_ISSUE, S_DRAIN, S_OUT
  } state_t;

  // where the read returning this cycle goes
  typedef enum logic [1:0] {CAP_NONE, CAP_BIAS, CAP_FEAT, CAP_WGT} cap_t;

  state_t              state_q;
  cap_t                cap_q;
  logic [NRN_W-1:0]    cap_nrn_q;
  logic [SIZE_W-1:0]   idx_q, last_idx_q;
  logic [NRN_W-1:0]    nrn_q;
  logic [K_W-1:0]      k_q;   // byte position being issued
  word_t               bias_q, feat_q;
  word_t [N_LANES-1:0] wgt_q;
  acc_t [N_LANES-1:0]  sum;
  word_t               result;
  logic                acc_done;

  function automatic logic [BYTE_W-1:0] requant(input acc_t s);
    if (s[ACC_W-1]) begin
      return '0;
    end
    if (|s[ACC_W-2:QUANT_LIMIT_BIT+1]) begin
      return {1'b0, {(BYTE_W-1){1'b1}}};  // saturate to 127
    end
    return BYTE_W'(s[QUANT_LIMIT_BIT:QUANT_SHIFT]);
  endfunction

  ////////////////////////////////////////////////////////////
  // memory requests and lane operands
  ////////////////////////////////////////////////////////////
  always_comb begin
    sq_req  = 1'b0;
    sq_addr = '0;
    case (state_q)
      S_BIAS: begin
        sq_req  = 1'b1;
        sq_addr = ADDR_W'(bias_base(MAX_WORDS));
      end
      S_FEAT: begin
        sq_req  = 1'b1;
        sq_addr = ADDR_W'(feat_base(MAX_WORDS)) + ADDR_W'(idx_q);
      end
      S_WGT: begin
        sq_req  = 1'b1;
        sq_addr = ADDR_W'(nrn_q * MAX_WORDS) + ADDR_W'(idx_q);
      end
      default: ;
    endcase
  end

  // wait out the last weight read before issuing
  assign lane_valid = (state_q == S_ISSUE) && (cap_q == CAP_NONE);
  assign lane_first = lane_valid && (idx_q == '0) && (k_q == '0);
  assign lane_last  = lane_valid && (idx_q == last_idx_q) && (k_q == K_W'(N_BYTES - 1));

  always_comb begin
    for (int n = 0; n < N_LANES; n++) begin
      lane_a[n] = feat_q[k_q*BYTE_W +: BYTE_W];
      lane_b[n] = wgt_q[n][k_q*BYTE_W +: BYTE_W];
      sum[n]    = lane_acc[n] + acc_t'(operand_t'(bias_q[n*BYTE_W +: BYTE_W]));
      result[n*BYTE_W +: BYTE_W] = requant(sum[n]);
    end
  end

  assign acc_done  = &lane_acc_valid;  // lanes run in lockstep
  assign comp_busy = (state_q != S_IDLE);

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      state_q   <= S_IDLE;
      cap_q     <= CAP_NONE;
      idx_q     <= '0;
      nrn_q     <= '0;
      k_q       <= '0;
      out_valid <= 1'b0;
    end else begin
      cap_q <= CAP_NONE;
      case (state_q)
        S_IDLE: begin
          if (start && cmd == CMD_COMPUTE) begin
            idx_q   <= '0;
            state_q <= S_BIAS;
          end
        end
        S_BIAS: begin
          if (sq_gnt) begin
            cap_q   <= CAP_BIAS;
            state_q <= S_FEAT;
          end
        end
        S_FEAT: begin
          if (sq_gnt) begin
            cap_q   <= CAP_FEAT;
            nrn_q   <= '0;
            state_q <= S_WGT;
          end
        end
        S_WGT: begin
          if (sq_gnt) begin
            cap_q <= CAP_WGT;
            nrn_q <= nrn_q + 1'b1;
            if (nrn_q == NRN_W'(N_LANES - 1)) begin
              k_q     <= '0;
              state_q <= S_ISSUE;
            end
          end
        end
        S_ISSUE: begin
          if (lane_valid) begin
            k_q <= k_q + 1'b1;
            if (k_q == K_W'(N_BYTES - 1)) begin
              if (idx_q == last_idx_q) begin
                state_q <= S_DRAIN;
              end else begin
                idx_q   <= idx_q + 1'b1;
                state_q <= S_FEAT;
              end
            end
          end
        end
        S_DRAIN: begin
          if (acc_done) begin
            out_valid <= 1'b1;
            state_q   <= S_OUT;
          end
        end
        S_OUT: begin
          if (out_ready) begin  // hold until the beat is taken
            out_valid <= 1'b0;
            state_q   <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // operand words, word count and packed result
  always_ff @(posedge clk) begin
    if (state_q == S_IDLE && start && cmd == CMD_COMPUTE) begin
      last_idx_q <= size - 1'b1;
    end
    if (sq_gnt) begin
      cap_nrn_q <= nrn_q;
    end
    case (cap_q)
      CAP_BIAS: bias_q <= sq_rdata;
      CAP_FEAT: feat_q <= sq_rdata;
      CAP_WGT:  wgt_q[cap_nrn_q] <= sq_rdata;
      default: ;
    endcase
    if (state_q == S_DRAIN && acc_done) begin
      out_data <= result;
    end
  end

endmodule

`default_nettype wire

// ==== src/mac_lane.sv ====
// one signed int8 multiply-accumulate lane, four pipeline stages
// a pair entered with valid lands in acc four cycles later; first
// restarts the sum and acc_valid pulses with the pair marked last

`default_nettype none
`timescale 1ns/1ps

module mac_lane
  import fc_pkg::*;
(
  input  logic     clk,
  input  logic     rstn,
  input  logic     valid,
  input  logic     first,
  input  logic     last,
  input  operand_t a,
  input  operand_t b,
  output acc_t     acc,
  output logic     acc_valid
);

  logic [BYTE_W-1:0]   a_mag, b_mag;
  logic [BYTE_W-1:0]   a_mag_q, b_mag_q;
  logic [BYTE_W+3:0]   pp_lo_q, pp_hi_q;  // a times low / high nibble of b
  logic [2*BYTE_W-1:0] prod_q;
  logic [2:0]          neg_sr;
  logic [2:0]          v_sr, f_sr, l_sr;  // control along stages 1..3
  acc_t                term;

  ////////////////////////////////////////////////////////////
  // stage 1: magnitudes and sign
  ////////////////////////////////////////////////////////////
  assign a_mag = a[BYTE_W-1] ? BYTE_W'(-a) : a;  // -128 gives 128
  assign b_mag = b[BYTE_W-1] ? BYTE_W'(-b) : b;

  always_ff @(posedge clk) begin
    a_mag_q <= a_mag;
    b_mag_q <= b_mag;
    // stage 2: two nibble partial products
    pp_lo_q <= a_mag_q * b_mag_q[3:0];
    pp_hi_q <= a_mag_q * b_mag_q[7:4];
    // stage 3: unsigned product
    prod_q  <= {4'b0, pp_lo_q} + {pp_hi_q, 4'b0};
    neg_sr  <= {neg_sr[1:0], a[BYTE_W-1] ^ b[BYTE_W-1]};
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      v_sr <= '0;
      f_sr <= '0;
      l_sr <= '0;
    end else begin
      v_sr <= {v_sr[1:0], valid};
      f_sr <= {f_sr[1:0], valid & first};
      l_sr <= {l_sr[1:0], valid & last};
    end
  end

  ////////////////////////////////////////////////////////////
  // stage 4: apply sign and accumulate
  ////////////////////////////////////////////////////////////
  always_comb begin
    term = neg_sr[2] ? -acc_t'(prod_q) : acc_t'(prod_q);
  end

  always_ff @(posedge clk) begin
    if (v_sr[2]) begin
      acc <= f_sr[2] ? term : acc + term;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      acc_valid <= 1'b0;
    end else begin
      acc_valid <= v_sr[2] & l_sr[2];
    end
  end

endmodule

`default_nettype wire

// ==== src/mem_arbiter.sv ====
// grants the single memory port to the loader or the sequencer
// loader has fixed priority; grants are given in the request cycle
// read data is steered back to the sequencer only when it owns the
// read that is in flight

`default_nettype none
`timescale 1ns/1ps

module mem_arbiter
  import fc_pkg::*;
#(
  parameter  int MAX_WORDS = 16,
  localparam int ADDR_W    = $clog2(mem_words(MAX_WORDS))
) (
  input  logic              clk,
  input  logic              rstn,
  // loader side
  input  logic              ld_req,
  input  logic              ld_we,
  input  logic [ADDR_W-1:0] ld_addr,
  input  word_t             ld_wdata,
  output logic              ld_gnt,
  // sequencer side, read only
  input  logic              sq_req,
  input  logic [ADDR_W-1:0] sq_addr,
  output logic              sq_gnt,
  output word_t             sq_rdata,
  // memory side
  output logic              en,
  output logic              we,
  output logic [ADDR_W-1:0] addr,
  output word_t             wdata,
  input  word_t             rdata
);

  logic sq_rd_q;  // sequencer read in flight

  assign ld_gnt = ld_req;
  assign sq_gnt = sq_req & ~ld_req;

  assign en    = ld_req | sq_req;
  assign we    = ld_req & ld_we;
  assign addr  = ld_req ? ld_addr : sq_addr;
  assign wdata = ld_wdata;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      sq_rd_q <= 1'b0;
    end else begin
      sq_rd_q <= sq_gnt;
    end
  end

  assign sq_rdata = sq_rd_q ? rdata : '0;

endmodule

`default_nettype wire

// ==== src/stream_loader.sv ====
// writes host stream words into the memory region chosen by a load command
// a weight load takes size words per neuron, four blocks in a row,
// block n landing in weight region n; a compute start is ignored

`default_nettype none
`timescale 1ns/1ps

module stream_loader
  import fc_pkg::*;
#(
  parameter  int MAX_WORDS = 16,
  localparam int ADDR_W    = $clog2(mem_words(MAX_WORDS)),
  localparam int SIZE_W    = $clog2(MAX_WORDS + 1)
) (
  input  logic              clk,
  input  logic              rstn,
  input  cmd_t              cmd,
  input  logic              start,
  input  logic [SIZE_W-1:0] size,
  input  logic              in_valid,
  input  word_t             in_data,
  output logic              in_ready,
  output logic              ld_req,
  output logic              ld_we,
  output logic [ADDR_W-1:0] ld_addr,
  output word_t             ld_wdata,
  input  logic              ld_gnt,
  output logic              load_busy
);

  logic              loading_q;
  logic [SIZE_W-1:0] idx_q;       // word within the current block
  logic [1:0]        nrn_q;       // block number, weights only
  logic [ADDR_W-1:0] base_q;
  logic [SIZE_W-1:0] last_idx_q;
  logic [1:0]        last_nrn_q;
  logic              beat;
  logic              load_start;

  assign load_start = start & ~loading_q & (cmd != CMD_COMPUTE);

  assign ld_req    = loading_q;
  assign in_ready  = loading_q & ld_gnt;
  assign beat      = in_valid & in_ready;
  assign ld_we     = in_valid;  // write lands only with the grant
  assign ld_wdata  = in_data;
  assign ld_addr   = base_q + ADDR_W'(nrn_q * MAX_WORDS) + ADDR_W'(idx_q);
  assign load_busy = loading_q;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      loading_q <= 1'b0;
      idx_q     <= '0;
      nrn_q     <= '0;
    end else if (load_start) begin
      loading_q <= 1'b1;
      idx_q     <= '0;
      nrn_q     <= '0;
    end else if (beat) begin
      if (idx_q == last_idx_q) begin
        idx_q <= '0;
        nrn_q <= nrn_q + 1'b1;
        if (nrn_q == last_nrn_q) begin
          loading_q <= 1'b0;  // last word of the command
        end
      end else begin
        idx_q <= idx_q + 1'b1;
      end
    end
  end

  // region and count of the running load
  always_ff @(posedge clk) begin
    if (load_start) begin
      last_idx_q <= size - 1'b1;
      last_nrn_q <= (cmd == CMD_LOAD_WEIGHT) ? 2'd3 : 2'd0;
      case (cmd)
        CMD_LOAD_FEAT: base_q <= ADDR_W'(feat_base(MAX_WORDS));
        CMD_LOAD_BIAS: base_q <= ADDR_W'(bias_base(MAX_WORDS));
        default:       base_q <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/word_sram.sv ====
// single-port word memory shared by the loader and the sequencer
// holds weights, the bias word and features; read data is registered
// and shows up one cycle after an enabled read

`default_nettype none
`timescale 1ns/1ps

module word_sram
  import fc_pkg::*;
#(
  parameter  int MAX_WORDS = 16,
  localparam int DEPTH     = mem_words(MAX_WORDS),
  localparam int ADDR_W    = $clog2(DEPTH)
) (
  input  logic              clk,
  input  logic              en,
  input  logic              we,
  input  logic [ADDR_W-1:0] addr,
  input  word_t             wdata,
  output word_t             rdata
);

  word_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        mem[addr] <= wdata;
      end else begin
        rdata <= mem[addr];  // read-first port, no bypass
      end
    end
  end

endmodule

`default_nettype wire

// ==== verification/fc_engine_properties.sv ====
// concurrent checks bound into the fc engine top level
// output word held under back-pressure, the sequencer never blocked
// by the loader at the memory port, and the input stream closed
// while a compute command runs

`default_nettype none
`timescale 1ns/1ps

module fc_engine_properties
  import fc_pkg::*;
(
  input logic  clk,
  input logic  rstn,
  input logic  out_valid,
  input logic  out_ready,
  input word_t out_data,
  input logic  in_ready,
  input logic  ld_gnt,
  input logic  sq_req,
  input logic  comp_busy
);

  int fail_count = 0;  // number of failed assertions

  a_out_hold: assert property (@(posedge clk) disable iff (!rstn)
    out_valid && !out_ready |=> out_valid && $stable(out_data))
  else begin
    fail_count++;
    $error("out_data changed or out_valid fell while out_ready was low");
  end

  a_seq_not_blocked: assert property (@(posedge clk) disable iff (!rstn)
    !(ld_gnt && sq_req))
  else begin
    fail_count++;
    $error("loader took the memory port while the sequencer requested it");
  end

  a_no_load_in_compute: assert property (@(posedge clk) disable iff (!rstn)
    !(comp_busy && in_ready))
  else begin
    fail_count++;
    $error("in_ready high during a compute command");
  end

endmodule

`default_nettype wire

// ==== verification/fc_engine_tb.sv ====
// testbench for the int8 fully connected layer engine
// each table row loads weights, bias and features over the input stream,
// runs a compute command and checks the packed output word against a
// reference model of the requantization rule

`default_nettype none
`timescale 1ns/1ps

module fc_engine_tb
  import fc_pkg::*;
();

  localparam int MAX_WORDS = 16;
  localparam int SIZE_W    = $clog2(MAX_WORDS + 1);
  localparam int LIMIT     = 2000;  // cycles allowed per wait
  localparam int N_ROWS    = 8;

  localparam int MODE_RAND = 0;
  localparam int MODE_MAX  = 1;
  localparam int MODE_NEG  = 2;  // positive features, negative weights and bias
  localparam int KIND_FEAT = 0;
  localparam int KIND_BIAS = 1;
  localparam int KIND_WGT  = 2;

  logic              clk, rstn, start, in_valid, out_ready;
  cmd_t              cmd;
  logic [SIZE_W-1:0] size;
  word_t             in_data, out_data;
  logic              in_ready, out_valid, busy;

  ////////////////////////////////////////////////////////////
  // stimulus table with one compute per row
  ////////////////////////////////////////////////////////////
  int    row_size   [N_ROWS] = '{1, 5, 16, 16, 4, 4, 5, 5};
  int    row_mode   [N_ROWS] = '{MODE_RAND, MODE_RAND, MODE_RAND, MODE_RAND,
                                 MODE_MAX, MODE_NEG, MODE_RAND, MODE_RAND};
  bit    row_reload [N_ROWS] = '{0, 0, 0, 1, 0, 0, 0, 1};  // features only
  int    row_stall  [N_ROWS] = '{0, 3, 0, 2, 5, 1, 0, 4};
  bit    row_fixed  [N_ROWS] = '{0, 0, 0, 0, 1, 1, 0, 0};  // expected from table
  word_t row_expect [N_ROWS] = '{0, 0, 0, 0, 32'h7f7f7f7f, 32'h0, 0, 0};

  // shadow of what was loaded into the engine
  word_t       feat_mem [MAX_WORDS];
  word_t       wgt_mem  [N_LANES][MAX_WORDS];
  word_t       bias_word;
  logic [15:0] lfsr_q;
  int          value_errors;
  int          timeouts;
  int          prop_fails;

  fc_engine #(.MAX_WORDS(MAX_WORDS)) UUT (
    .clk, .rstn, .cmd, .start, .size, .in_valid, .in_data, .in_ready,
    .out_valid, .out_data, .out_ready, .busy
  );

  bind fc_engine fc_engine_properties u_props (
    .clk, .rstn, .out_valid, .out_ready, .out_data, .in_ready,
    .ld_gnt, .sq_req, .comp_busy
  );

  always #50 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // data sources and reference model
  ////////////////////////////////////////////////////////////
  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [7:0] next_byte();
    logic [7:0] b;
    b = '0;
    for (int i = 0; i < 8; i++) begin
      lfsr_q = lfsr_step(lfsr_q);  // one step per bit
      b      = {b[6:0], lfsr_q[0]};
    end
    return b;
  endfunction

  function automatic word_t make_word(input int mode, input int kind);
    word_t w;
    w = '0;
    if (mode == MODE_MAX) begin
      w = 32'h7f7f7f7f;
    end else if (mode == MODE_NEG) begin
      w = (kind == KIND_FEAT) ? 32'h7f7f7f7f : 32'h80808080;
    end else begin
      for (int k = 0; k < 4; k++) begin
        w[k*8 +: 8] = next_byte();
      end
    end
    return w;
  endfunction

  function automatic int sbyte(input word_t w, input int k);
    operand_t b;
    b = w[k*8 +: 8];
    return int'(b);
  endfunction

  // dot product plus bias byte clamped to a 7-bit byte
  function automatic word_t model_result(input int n);
    word_t res;
    int    s;
    res = '0;
    for (int j = 0; j < N_LANES; j++) begin
      s = sbyte(bias_word, j);
      for (int i = 0; i < n; i++) begin
        for (int k = 0; k < 4; k++) begin
          s += sbyte(feat_mem[i], k) * sbyte(wgt_mem[j][i], k);
        end
      end
      if (s < 0) begin
        res[j*8 +: 8] = 8'd0;
      end else if ((s >>> (QUANT_LIMIT_BIT + 1)) != 0) begin
        res[j*8 +: 8] = 8'd127;
      end else begin
        res[j*8 +: 8] = {1'b0, 7'(s >>> QUANT_SHIFT)};
      end
    end
    return res;
  endfunction

  ////////////////////////////////////////////////////////////
  // checks and bus tasks
  ////////////////////////////////////////////////////////////
  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("Error: %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      value_errors++;
      $display("Error: %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("timeout at %0t: %s", $time, what);
  endtask

  task automatic pulse_start(input cmd_t c, input int n);
    cmd   = c;
    size  = SIZE_W'(n);
    start = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
  endtask

  task automatic send_word(input word_t w);
    int t;
    if (timeouts != 0) return;
    in_valid = 1'b1;
    in_data  = w;
    t = 0;
    while (!in_ready) begin
      @(posedge clk);
      #1;
      t++;
      if (t > LIMIT) begin
        report_timeout("in_ready never rose for a stream word");
        in_valid = 1'b0;
        return;
      end
    end
    @(posedge clk);  // beat taken here
    #1;
    in_valid = 1'b0;
  endtask

  task automatic wait_idle();
    int t;
    t = 0;
    while (busy && timeouts == 0) begin
      @(posedge clk);
      #1;
      t++;
      if (t > LIMIT) begin
        report_timeout("busy stayed high after a command");
      end
    end
  endtask

  task automatic load_words(input cmd_t c, input int n);
    pulse_start(c, n);
    if (c == CMD_LOAD_WEIGHT) begin
      for (int j = 0; j < N_LANES; j++) begin
        for (int i = 0; i < n; i++) begin
          send_word(wgt_mem[j][i]);
        end
      end
    end else if (c == CMD_LOAD_BIAS) begin
      send_word(bias_word);
    end else begin
      for (int i = 0; i < n; i++) begin
        send_word(feat_mem[i]);
      end
    end
    wait_idle();
    check_bit("in_ready", in_ready, 1'b0);
  endtask

  task automatic run_compute(input int n, input int stall, input word_t exp);
    word_t held;
    int    t;
    pulse_start(CMD_COMPUTE, n);
    check_bit("busy", busy, 1'b1);
    t = 0;
    while (!out_valid) begin
      @(posedge clk);
      #1;
      t++;
      if (t > LIMIT) begin
        report_timeout("out_valid never rose after compute");
        return;
      end
    end
    held = out_data;
    repeat (stall) begin  // sink stalls while the word holds
      @(posedge clk);
      #1;
      check_bit("out_valid", out_valid, 1'b1);
      check_word("out_data", out_data, held);
    end
    out_ready = 1'b1;
    @(posedge clk);
    #1;
    out_ready = 1'b0;
    check_word("out_data", held, exp);
    check_bit("out_valid", out_valid, 1'b0);
    check_bit("busy", busy, 1'b0);
  endtask

  task automatic run_row(input int r);
    int    n;
    word_t exp;
    n = row_size[r];
    if (!row_reload[r]) begin
      bias_word = make_word(row_mode[r], KIND_BIAS);
      for (int j = 0; j < N_LANES; j++) begin
        for (int i = 0; i < n; i++) begin
          wgt_mem[j][i] = make_word(row_mode[r], KIND_WGT);
        end
      end
    end
    for (int i = 0; i < n; i++) begin
      feat_mem[i] = make_word(row_mode[r], KIND_FEAT);
    end
    if (!row_reload[r]) begin
      load_words(CMD_LOAD_WEIGHT, n);
      load_words(CMD_LOAD_BIAS, 1);
    end
    load_words(CMD_LOAD_FEAT, n);
    if (timeouts != 0) return;
    exp = row_fixed[r] ? row_expect[r] : model_result(n);
    $display("row %0d size %0d expecting %h", r, n, exp);
    run_compute(n, row_stall[r], exp);
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    clk          = 1'b0;
    rstn         = 1'b0;
    cmd          = CMD_LOAD_FEAT;
    start        = 1'b0;
    size         = '0;
    in_valid     = 1'b0;
    in_data      = '0;
    out_ready    = 1'b0;
    lfsr_q       = 16'd50;
    value_errors = 0;
    timeouts     = 0;
    repeat (16) @(posedge clk);
    #1;
    rstn = 1'b1;
    repeat (3) begin  // quiet until the first start
      check_bit("in_ready", in_ready, 1'b0);
      check_bit("out_valid", out_valid, 1'b0);
      check_bit("busy", busy, 1'b0);
      @(posedge clk);
      #1;
    end
    for (int r = 0; r < N_ROWS; r++) begin
      if (timeouts == 0) run_row(r);
    end
    prop_fails = UUT.u_props.fail_count;
    $display("value errors: %0d, timeouts: %0d, assertion failures: %0d",
             value_errors, timeouts, prop_fails);
    if (value_errors == 0 && timeouts == 0 && prop_fails == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
